/* project.f */
+incdir+rtl
rtl/trace_pkg.sv
rtl/ctrl_pkg.sv
rtl/monitor_cfg_if.sv
rtl/ctrl_regs.sv
rtl/trace_gate.sv
rtl/event_counters.sv
rtl/trace_packer.sv
rtl/stream_fifo.sv
rtl/trace_monitor_top.sv
testbench/trace_monitor_assertions.sv
testbench/tb_trace_monitor.sv

/* rtl/ctrl_pkg.sv */
/*
 * control port types for the trace monitor
 * addresses select which capture setting a write updates
 */
`include "trace_params.svh"

package ctrl_pkg;

    // register map of the control write port
    typedef enum logic [3:0] {
        // trigger enables, bit 0 of the data word
        START_EN    = 4'd0,
        END_EN      = 4'd1,
        // trigger addresses, exact pc match
        START_ADDR  = 4'd2,
        END_ADDR    = 4'd3,
        // range enables, bit 0 of the data word
        LOWER_EN    = 4'd4,
        UPPER_EN    = 4'd5,
        // range bounds, both inclusive
        LOWER_BOUND = 4'd6,
        UPPER_BOUND = 4'd7
    } ctrl_addr_t;

    // data word, wide enough for a full address
    typedef logic [`TRACE_XLEN-1:0] ctrl_word_t;

endpackage

/* rtl/ctrl_regs.sv */
/*
 * control registers of the trace monitor
 * level triggered write port, a write lands at the edge ending its cycle
 */
`timescale 1ns/1ps

module ctrl_regs import ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_addr_t ctrl_addr,
    input  ctrl_word_t ctrl_wdata,
    input  logic       ctrl_write,
    monitor_cfg_if.regs cfg
);

    // gate holds off trigger updates during a write
    assign cfg.ctrl_write = ctrl_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.start_en    <= 1'b0;
            cfg.end_en      <= 1'b0;
            cfg.start_addr  <= '0;
            // end address and upper bound open wide
            cfg.end_addr    <= '1;
            cfg.lower_en    <= 1'b0;
            cfg.upper_en    <= 1'b0;
            cfg.lower_bound <= '0;
            cfg.upper_bound <= '1;
        end else if (ctrl_write) begin
            case (ctrl_addr)
                START_EN:    cfg.start_en    <= ctrl_wdata[0];
                END_EN:      cfg.end_en      <= ctrl_wdata[0];
                START_ADDR:  cfg.start_addr  <= ctrl_wdata;
                END_ADDR:    cfg.end_addr    <= ctrl_wdata;
                LOWER_EN:    cfg.lower_en    <= ctrl_wdata[0];
                UPPER_EN:    cfg.upper_en    <= ctrl_wdata[0];
                LOWER_BOUND: cfg.lower_bound <= ctrl_wdata;
                UPPER_BOUND: cfg.upper_bound <= ctrl_wdata;
                // addresses 8..15 unmapped
                default: begin
                end
            endcase
        end
    end

endmodule

/* rtl/event_counters.sv */
/*
 * one saturating counter per performance event bit
 * all counters restart from zero at each capture
 */
`timescale 1ns/1ps
`include "trace_params.svh"

module event_counters import trace_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         capture,
    input  logic [`TRACE_NUM_EVENTS-1:0] events,
    output event_counts_t                counts
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counts <= '0;
        end else if (capture) begin
            // events seen in the capture cycle itself are dropped
            counts <= '0;
        end else begin
            for (int i = 0; i < `TRACE_NUM_EVENTS; i++) begin
                // hold at all ones
                if (events[i] && (counts[i] != '1)) begin
                    counts[i] <= counts[i] + event_count_t'(1);
                end
            end
        end
    end

endmodule

/* rtl/monitor_cfg_if.sv */
/*
 * capture configuration from the control registers to the gate
 */
`timescale 1ns/1ps
`include "trace_params.svh"

interface monitor_cfg_if;

    // start/end triggers
    logic                   start_en;
    logic                   end_en;
    logic [`TRACE_XLEN-1:0] start_addr;
    logic [`TRACE_XLEN-1:0] end_addr;

    // monitored range
    logic                   lower_en;
    logic                   upper_en;
    logic [`TRACE_XLEN-1:0] lower_bound;
    logic [`TRACE_XLEN-1:0] upper_bound;

    // high while a control write happens this cycle
    logic                   ctrl_write;

    modport regs (
        output start_en, end_en, start_addr, end_addr,
        output lower_en, upper_en, lower_bound, upper_bound,
        output ctrl_write
    );

    modport gate (
        input start_en, end_en, start_addr, end_addr,
        input lower_en, upper_en, lower_bound, upper_bound,
        input ctrl_write
    );

endinterface

/* rtl/stream_fifo.sv */
/*
 * circular buffer with an axi4-stream read side
 * head entry sits on rd_data with tvalid until tready takes it
 */
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 8
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  payload_t wr_data,
    output logic     full,
    output logic     tvalid,
    input  logic     tready,
    output payload_t rd_data
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;

    payload_t mem [depth];

    logic [aw-1:0]          wr_ptr;
    logic [aw-1:0]          rd_ptr;
    logic [$clog2(depth+1)-1:0] count;

    logic push;
    logic pop;

    assign full    = (count == depth);
    assign tvalid  = (count != 0);
    assign rd_data = mem[rd_ptr];

    // full comes from the registered count so a pop does not free space this cycle
    assign push = wr_en && !full;
    assign pop  = tvalid && tready;

    // payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // explicit wrap since depth need not be a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rtl/trace_gate.sv */
/*
 * per cycle capture decision
 * range and trigger checks plus the stop after two wfi in a row
 */
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_gate (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  logic                          pc_valid,
    input  logic [`TRACE_XLEN-1:0]        pc,
    input  logic [`TRACE_INSTR_WIDTH-1:0] instr,
    monitor_cfg_if.gate                   cfg,
    output logic                          capture,
    output logic                          capture_wfi
);

    logic       start_reached;
    logic       end_reached;
    // saturates at 2, capture stops there
    logic [1:0] wfi_cnt;

    logic is_wfi;
    logic start_hit;
    logic end_hit;
    logic in_range;
    logic trig_open;

    assign is_wfi    = (instr == `TRACE_WFI_INSTR);
    assign start_hit = cfg.start_en && (pc == cfg.start_addr);
    assign end_hit   = cfg.end_en && (pc == cfg.end_addr);

    // disabled bound always passes
    assign in_range = (!cfg.lower_en || (pc >= cfg.lower_bound)) &&
                      (!cfg.upper_en || (pc <= cfg.upper_bound));

    // trigger flags are registered, a match opens/closes from the next cycle
    assign trig_open = (!cfg.start_en || start_reached) &&
                       (!cfg.end_en || !end_reached);

    assign capture     = en && pc_valid && (wfi_cnt < 2'd2) && trig_open && in_range;
    assign capture_wfi = capture && is_wfi;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_reached <= 1'b0;
            end_reached   <= 1'b0;
            wfi_cnt       <= 2'd0;
        end else begin
            // no trigger tracking while the config is being written
            if (!cfg.ctrl_write) begin
                if (start_hit) begin
                    start_reached <= 1'b1;
                    end_reached   <= 1'b0;
                end
                // end wins on a double match
                if (end_hit) begin
                    end_reached   <= 1'b1;
                    start_reached <= 1'b0;
                end
            end

            if (is_wfi && en && (wfi_cnt < 2'd2)) begin
                wfi_cnt <= wfi_cnt + 2'd1;
            end else if (!is_wfi) begin
                wfi_cnt <= 2'd0;
            end
        end
    end

endmodule

/* rtl/trace_monitor_top.sv */
/*
 * trace monitor beside a risc-v core
 * captures retired instructions into packets, sent out on an axi4-stream master
 */
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_monitor_top import trace_pkg::*, ctrl_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  logic                          pc_valid,
    input  logic [`TRACE_INSTR_WIDTH-1:0] instr,
    input  logic [`TRACE_XLEN-1:0]        pc,
    input  logic [`TRACE_NUM_EVENTS-1:0]  performance_events,
    // control write port
    input  ctrl_addr_t                    ctrl_addr,
    input  ctrl_word_t                    ctrl_wdata,
    input  logic                          ctrl_write,
    // packets per tlast, 0 for wfi only
    input  logic [31:0]                   tlast_interval,
    // stream master
    output logic                          m_axis_tvalid,
    input  logic                          m_axis_tready,
    output trace_pkt_t                    m_axis_tdata,
    output logic                          m_axis_tlast
);

    monitor_cfg_if cfg_if ();

    logic          capture;
    logic          capture_wfi;
    event_counts_t counts;
    logic          wr_en;
    trace_beat_t   wr_beat;
    logic          full;
    trace_beat_t   rd_beat;

    ctrl_regs u_ctrl_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_addr  (ctrl_addr),
        .ctrl_wdata (ctrl_wdata),
        .ctrl_write (ctrl_write),
        .cfg        (cfg_if)
    );

    trace_gate u_trace_gate (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .pc_valid    (pc_valid),
        .pc          (pc),
        .instr       (instr),
        .cfg         (cfg_if),
        .capture     (capture),
        .capture_wfi (capture_wfi)
    );

    event_counters u_event_counters (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (capture),
        .events  (performance_events),
        .counts  (counts)
    );

    trace_packer u_trace_packer (
        .clk            (clk),
        .rst_n          (rst_n),
        .capture        (capture),
        .capture_wfi    (capture_wfi),
        .instr          (instr),
        .pc             (pc),
        .counts         (counts),
        .tlast_interval (tlast_interval),
        .full           (full),
        .wr_en          (wr_en),
        .wr_beat        (wr_beat)
    );

    stream_fifo #(
        .payload_t (trace_beat_t),
        .depth     (`TRACE_FIFO_DEPTH)
    ) u_stream_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_data (wr_beat),
        .full    (full),
        .tvalid  (m_axis_tvalid),
        .tready  (m_axis_tready),
        .rd_data (rd_beat)
    );

    // split the head beat onto tdata/tlast
    assign m_axis_tdata = rd_beat.pkt;
    assign m_axis_tlast = rd_beat.last;

endmodule

/* rtl/trace_packer.sv */
/*
 * builds trace packets from captures
 * timestamps each capture, tracks the tlast interval, pushes into the fifo
 */
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_packer import trace_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          capture,
    input  logic                          capture_wfi,
    input  logic [`TRACE_INSTR_WIDTH-1:0] instr,
    input  logic [`TRACE_XLEN-1:0]        pc,
    input  event_counts_t                 counts,
    input  logic [31:0]                   tlast_interval,
    input  logic                          full,
    output logic                          wr_en,
    output trace_beat_t                   wr_beat
);

    logic [`TRACE_DELTA_WIDTH-1:0] clk_cnt;
    logic [`TRACE_DELTA_WIDTH-1:0] last_ts;
    // packets written since the last tlast
    logic [31:0]                   pkt_cnt;
    logic                          interval_hit;

    // drop on full, pop in the same cycle does not count
    assign wr_en = capture && !full;

    // >= so a lowered interval still closes the burst
    assign interval_hit = (tlast_interval != 32'd0) && (pkt_cnt >= tlast_interval - 32'd1);

    assign wr_beat.pkt.instr  = instr;
    assign wr_beat.pkt.delta  = clk_cnt - last_ts;
    assign wr_beat.pkt.pc     = pc;
    assign wr_beat.pkt.counts = counts;
    assign wr_beat.last       = capture_wfi || interval_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_cnt <= '0;
            last_ts <= '0;
            pkt_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            // a dropped capture still moves the timestamp
            if (capture) begin
                last_ts <= clk_cnt;
            end
            if (wr_en) begin
                pkt_cnt <= wr_beat.last ? 32'd0 : pkt_cnt + 32'd1;
            end
        end
    end

endmodule

/* rtl/trace_params.svh */
/*
 * width and size constants for the trace monitor
 * include wherever a width, the event count or the wfi encoding is needed
 */
`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

// pc and trigger/bound address width
`define TRACE_XLEN 32

// one retired instruction
`define TRACE_INSTR_WIDTH 32

// free running clock counter and timestamp delta
`define TRACE_DELTA_WIDTH 32

// performance event inputs, one counter each
`define TRACE_NUM_EVENTS 8
// per event count, saturates at all ones
`define TRACE_EVENT_CNT_WIDTH 8

// output queue entries
`define TRACE_FIFO_DEPTH 8

// wfi encoding in rv32i
`define TRACE_WFI_INSTR 32'h1050_0073

`endif

/* rtl/trace_pkg.sv */
/*
 * trace packet and stream beat types
 * a packet is exactly the tdata of the output stream
 */
`include "trace_params.svh"

package trace_pkg;

    // one saturating event count
    typedef logic [`TRACE_EVENT_CNT_WIDTH-1:0] event_count_t;

    // all event counts, index i for event bit i
    typedef event_count_t [`TRACE_NUM_EVENTS-1:0] event_counts_t;

    // instr in the top bits, counts at the bottom
    typedef struct packed {
        logic [`TRACE_INSTR_WIDTH-1:0] instr;
        logic [`TRACE_DELTA_WIDTH-1:0] delta;
        logic [`TRACE_XLEN-1:0]        pc;
        event_counts_t                 counts;
    } trace_pkt_t;

    // fifo payload, packet plus tlast
    typedef struct packed {
        trace_pkt_t pkt;
        logic       last;
    } trace_beat_t;

endpackage

/* run.sh */
#!/bin/sh
# build the testbench with verilator and run it, the exit status is the verdict
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_trace_monitor \
    && ./obj_dir/Vtb_trace_monitor \
    || { echo "simulation failed"; exit 1; }

/* testbench/tb_trace_monitor.sv */
/*
 * random testbench for the trace monitor top level
 * a cycle model predicts every packet, its tlast and every drop at a full fifo
 */
`timescale 1ns/1ps
`include "trace_params.svh"

module tb_trace_monitor import trace_pkg::*, ctrl_pkg::*; ();

    logic                          clk;
    logic                          rst_n;
    logic                          en;
    logic                          pc_valid;
    logic [`TRACE_INSTR_WIDTH-1:0] instr;
    logic [`TRACE_XLEN-1:0]        pc;
    logic [`TRACE_NUM_EVENTS-1:0]  performance_events;
    ctrl_addr_t                    ctrl_addr;
    ctrl_word_t                    ctrl_wdata;
    logic                          ctrl_write;
    logic [31:0]                   tlast_interval;
    logic                          m_axis_tvalid;
    logic                          m_axis_tready;
    trace_pkt_t                    m_axis_tdata;
    logic                          m_axis_tlast;

    // model state with cfg indexed by control address
    ctrl_word_t    cfg [8];
    logic          start_reached;
    logic          end_reached;
    int            wfi_cnt;
    event_counts_t m_counts;
    logic [31:0]   clk_cnt;
    logic [31:0]   last_ts;
    // packets written since the last tlast
    logic [31:0]   pkt_cnt;
    trace_beat_t   q [$];
    int            seed = 88751;
    int            n_sent;
    int            n_dropped;
    // rare tready and steady captures so the fifo fills
    logic          slow_sink;

    trace_monitor_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pkt(input trace_pkt_t got, input trace_pkt_t exp);
        if (got !== exp) begin
            $display("ERR %0t: tdata instr %h pc %h delta %0d counts %h", $time,
                     got.instr, got.pc, got.delta, got.counts);
            $display("    expected instr %h pc %h delta %0d counts %h",
                     exp.instr, exp.pc, exp.delta, exp.counts);
            abort_run("packet on the stream differs from the model");
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: tlast %b, expected %b", $time, got, exp);
            abort_run("tlast on the stream differs from the model");
        end
    endtask

    // evaluated at the falling edge where inputs and outputs are settled
    task automatic model_cycle();
        trace_beat_t beat;
        logic        full;
        logic        cap;
        logic        wfi;
        // full before any pop of this cycle
        full = (q.size() == `TRACE_FIFO_DEPTH);
        if (m_axis_tvalid !== (q.size() != 0)) begin
            $display("ERR %0t: tvalid %b, expected %b", $time, m_axis_tvalid, q.size() != 0);
            abort_run("stream valid differs from the model");
        end
        if (m_axis_tvalid && m_axis_tready) begin
            check_pkt(m_axis_tdata, q[0].pkt);
            check_last(m_axis_tlast, q[0].last);
            void'(q.pop_front());
        end
        wfi = (instr == `TRACE_WFI_INSTR);
        cap = en && pc_valid && (wfi_cnt < 2) &&
              (!cfg[START_EN][0] || start_reached) && (!cfg[END_EN][0] || !end_reached) &&
              (!cfg[LOWER_EN][0] || pc >= cfg[LOWER_BOUND]) &&
              (!cfg[UPPER_EN][0] || pc <= cfg[UPPER_BOUND]);
        if (cap) begin
            beat.pkt.instr  = instr;
            beat.pkt.delta  = clk_cnt - last_ts;
            beat.pkt.pc     = pc;
            beat.pkt.counts = m_counts;
            // a lowered interval closes the burst at once
            beat.last = wfi || ((tlast_interval != 0) && (pkt_cnt + 1 >= tlast_interval));
            if (full) begin
                n_dropped++;
            end else begin
                q.push_back(beat);
                pkt_cnt = beat.last ? 32'd0 : pkt_cnt + 32'd1;
                n_sent++;
            end
            // dropped captures still move the timestamp
            last_ts = clk_cnt;
        end
        for (int i = 0; i < `TRACE_NUM_EVENTS; i++) begin
            if (cap) begin
                m_counts[i] = '0;
            end else if (performance_events[i] && (m_counts[i] != 8'hff)) begin
                m_counts[i] = m_counts[i] + 8'd1;
            end
        end
        // triggers frozen during a control write
        // end wins on a double match
        if (!ctrl_write) begin
            if (cfg[START_EN][0] && (pc == cfg[START_ADDR])) begin
                start_reached = 1'b1;
                end_reached   = 1'b0;
            end
            if (cfg[END_EN][0] && (pc == cfg[END_ADDR])) begin
                end_reached   = 1'b1;
                start_reached = 1'b0;
            end
        end
        if (wfi && en && (wfi_cnt < 2)) begin
            wfi_cnt++;
        end else if (!wfi) begin
            wfi_cnt = 0;
        end
        if (ctrl_write && (int'(ctrl_addr) < 8)) begin
            cfg[ctrl_addr] = ctrl_wdata;
        end
        clk_cnt = clk_cnt + 32'd1;
    endtask

    // one cycle with new inputs 1 ns after the rising edge
    task automatic step();
        @(negedge clk);
        model_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_ctrl(input ctrl_addr_t addr, input ctrl_word_t data);
        ctrl_addr  = addr;
        ctrl_wdata = data;
        ctrl_write = 1'b1;
        step();
        ctrl_write = 1'b0;
    endtask

    // kind 0 range, 1 triggers, 2 wfi runs, 3 sparse captures for saturation
    task automatic run_phase(input int kind, input int cycles);
        logic [31:0] r;
        for (int c = 0; c < cycles; c++) begin
            r                  = $random(seed);
            en                 = (r[3:0] != 4'd0);
            pc_valid           = (kind == 3) ? (r[12:4] == 9'd0) : (slow_sink || r[4]);
            pc                 = 32'h1000 + {24'd0, r[15:8]};
            instr              = $random(seed);
            performance_events = (kind == 3) ? (r[23:16] | r[31:24]) : r[23:16];
            m_axis_tready      = slow_sink ? (r[27:24] == 4'd0) : (r[27:26] != 2'd0);
            ctrl_write         = 1'b0;
            if (kind == 1) begin
                // half the time sit on one of the trigger addresses
                if (r[7:6] == 2'd0) begin
                    pc = cfg[START_ADDR];
                end else if (r[7:6] == 2'd1) begin
                    pc = cfg[END_ADDR];
                end
                // writes that keep the config and only hold off trigger tracking
                ctrl_write = (r[29:28] == 2'd0);
                ctrl_addr  = r[30] ? START_EN : ctrl_addr_t'({1'b1, r[10:8]});
                ctrl_wdata = 32'd1;
            end
            if ((kind == 2) && (r[6:5] != 2'd0)) begin
                instr = `TRACE_WFI_INSTR;
            end
            step();
        end
    endtask

    initial begin
        rst_n              = 1'b0;
        en                 = 1'b0;
        pc_valid           = 1'b0;
        instr              = '0;
        pc                 = '0;
        performance_events = '0;
        ctrl_addr          = START_EN;
        ctrl_wdata         = '0;
        ctrl_write         = 1'b0;
        tlast_interval     = '0;
        m_axis_tready      = 1'b0;
        slow_sink          = 1'b0;
        foreach (cfg[i]) begin
            cfg[i] = '0;
        end
        cfg[END_ADDR]      = '1;
        cfg[UPPER_BOUND]   = '1;
        start_reached      = 1'b0;
        end_reached        = 1'b0;
        wfi_cnt            = 0;
        m_counts           = '0;
        clk_cnt            = '0;
        last_ts            = '0;
        pkt_cnt            = '0;
        n_sent             = 0;
        n_dropped          = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // range window inside the pc spread
        write_ctrl(LOWER_BOUND, 32'h1000 + ($random(seed) & 32'h7f));
        write_ctrl(UPPER_BOUND, 32'h1080 + ($random(seed) & 32'h7f));
        write_ctrl(LOWER_EN, 32'd1);
        write_ctrl(UPPER_EN, 32'd1);
        tlast_interval = 32'd3 + ($random(seed) & 32'h3);
        run_phase(0, 400);
        slow_sink = 1'b1;
        run_phase(0, 300);
        slow_sink = 1'b0;

        write_ctrl(LOWER_EN, 32'd0);
        write_ctrl(UPPER_EN, 32'd0);
        write_ctrl(START_ADDR, 32'h1000 + ($random(seed) & 32'hff));
        write_ctrl(END_ADDR, 32'h1000 + ($random(seed) & 32'hff));
        write_ctrl(START_EN, 32'd1);
        write_ctrl(END_EN, 32'd1);
        tlast_interval = $random(seed) & 32'h7;
        run_phase(1, 400);

        write_ctrl(START_EN, 32'd0);
        write_ctrl(END_EN, 32'd0);
        // interval of at least 2 so a wfi tlast visibly restarts the count
        tlast_interval = 32'd2 + ($random(seed) & 32'h3);
        run_phase(2, 300);
        tlast_interval = 32'd0;
        run_phase(3, 2000);

        // drain with the sink always ready
        en            = 1'b0;
        m_axis_tready = 1'b1;
        for (int i = 0; (i < 100) && (q.size() != 0); i++) begin
            step();
        end
        if (q.size() != 0) begin
            abort_run("timeout while waiting for the queued packets to leave");
        end else if (n_sent < 50) begin
            abort_run("too few packets were sent to exercise the monitor");
        end else if (n_dropped == 0) begin
            abort_run("no capture was dropped at a full fifo");
        end else begin
            $display("sent %0d packets, dropped %0d", n_sent, n_dropped);
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* testbench/trace_monitor_assertions.sv */
/*
 * axi4-stream protocol checks on the trace monitor output
 * bound to every trace_monitor_top instance
 */
`timescale 1ns/1ps

module trace_monitor_assertions import trace_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       m_axis_tvalid,
    input logic       m_axis_tready,
    input trace_pkt_t m_axis_tdata,
    input logic       m_axis_tlast
);

    // a waiting beat is never withdrawn
    a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid)
        else $error("tvalid dropped before a transfer");

    // payload frozen while the sink stalls
    a_data_held: assert property (@(posedge clk) disable iff (!rst_n)
        m_axis_tvalid && !m_axis_tready |=> $stable(m_axis_tdata) && $stable(m_axis_tlast))
        else $error("tdata or tlast changed while waiting for tready");

    // fifo empty once a reset edge has passed
    a_reset_idle: assert property (@(posedge clk)
        !rst_n |=> !m_axis_tvalid)
        else $error("tvalid high after a reset edge");

endmodule

bind trace_monitor_top trace_monitor_assertions u_stream_checks (.*);
